/* verilog.f */
logic/lsu_pkg.sv
logic/lsu_if.sv
logic/mem_decode.sv
logic/dcache_exec.sv
logic/mem_result.sv
logic/mem_unit.sv
bench/mem_responder.sv
bench/tb_mem_unit.sv

/* Bender.yml */
package:
  name: mem_unit

sources:
  - logic/lsu_pkg.sv
  - logic/lsu_if.sv
  - logic/mem_decode.sv
  - logic/dcache_exec.sv
  - logic/mem_result.sv
  - logic/mem_unit.sv
  - target: test
    files:
      - bench/mem_responder.sv
      - bench/tb_mem_unit.sv

/* bench/tb_mem_unit.sv */
module tb_mem_unit import lsu_pkg::*; ();

  // Expected writeback, built when the op is accepted
  typedef struct packed {
    logic [TAG_W-1:0] tag;
    logic             we;
    logic             excp;
    logic [XLEN-1:0]  data;
    logic [31:0]      reads;
    logic [31:0]      reqs;
  } wb_exp_t;

  logic             clk;
  logic             rst_n;
  logic             op_valid_i;
  logic             op_ready_o;
  mem_op_e          op_code_i;
  mem_size_e        op_size_i;
  logic             op_signed_i;
  logic [XLEN-1:0]  op_base_i;
  logic [IMM_W-1:0] op_imm_i;
  logic [XLEN-1:0]  op_wdata_i;
  logic [TAG_W-1:0] op_tag_i;
  logic             mem_req_valid_o;
  logic             mem_req_ready_i;
  logic             mem_req_we_o;
  logic [XLEN-1:0]  mem_req_addr_o;
  logic [XLEN-1:0]  mem_req_wdata_o;
  logic [BE_W-1:0]  mem_req_be_o;
  logic             mem_rsp_valid_i;
  logic [XLEN-1:0]  mem_rsp_rdata_i;
  logic             wb_valid_o;
  logic             wb_ready_i;
  logic             wb_we_o;
  logic [XLEN-1:0]  wb_data_o;
  logic [TAG_W-1:0] wb_tag_o;
  logic             wb_excp_o;
  int               read_cnt;
  int               req_cnt;

  // Reference model state
  logic [31:0]       model_mem [256];
  logic [LINE_CNT-1:0] model_valid;
  logic [CTAG_W-1:0] model_tag [LINE_CNT];
  wb_exp_t           exp_q [$];
  int                exp_reads;
  int                exp_reqs;

  integer      seed;
  int          errors;
  int          checks;
  int          test_errors;
  int          accepted;
  int          generated;
  int          total_ops;
  logic        timed_out;
  logic        op_held;
  logic        held_wb;
  logic [37:0] held_rec;
  logic [5:0]  last_word;
  logic [TAG_W-1:0] next_tag;
  string       test_name [5] = '{"loads", "store_load", "cacop", "misaligned", "mixed_stalls"};

  mem_unit mem_unit_inst (.*);

  mem_responder responder_inst (
    .clk             (clk),
    .rst_n           (rst_n),
    .mem_req_valid_i (mem_req_valid_o),
    .mem_req_ready_o (mem_req_ready_i),
    .mem_req_we_i    (mem_req_we_o),
    .mem_req_addr_i  (mem_req_addr_o),
    .mem_req_wdata_i (mem_req_wdata_o),
    .mem_req_be_i    (mem_req_be_o),
    .mem_rsp_valid_o (mem_rsp_valid_i),
    .mem_rsp_rdata_o (mem_rsp_rdata_i),
    .read_cnt_o      (read_cnt),
    .req_cnt_o       (req_cnt)
  );

  initial clk = 1'b0;
  always #20 clk = ~clk;

  // ========================================================================
  // Checking helpers
  // ========================================================================

  task automatic expect_equal(input string name, input logic [63:0] got, input logic [63:0] exp);
    checks++;
    if (got !== exp) begin
      $display("Mismatch at time %0t: %s got %0h expected %0h", $time, name, got, exp);
      errors++;
      test_errors++;
    end
  endtask

  task automatic report_error(input string msg);
    $display("Error at time %0t: %s", $time, msg);
    errors++;
    test_errors++;
  endtask

  // Byte or half picked from the word, then extended
  function automatic logic [31:0] extract(input logic [31:0] word, input logic [1:0] off,
                                          input mem_size_e size, input logic sgn);
    logic [31:0] v;
    v = word >> (8 * off);
    case (size)
      SZ_BYTE: v = sgn ? {{24{v[7]}}, v[7:0]} : {24'd0, v[7:0]};
      SZ_HALF: v = sgn ? {{16{v[15]}}, v[15:0]} : {16'd0, v[15:0]};
      default: v = word;
    endcase
    return v;
  endfunction

  // ========================================================================
  // Reference model, applied in acceptance order
  // ========================================================================

  task automatic model_accept();
    logic [31:0]       ea;
    logic              mis;
    logic [3:0]        idx;
    logic [CTAG_W-1:0] ctag;
    logic [7:0]        w;
    int                nbytes;
    wb_exp_t           e;
    ea   = op_base_i + {{20{op_imm_i[11]}}, op_imm_i};
    mis  = (op_size_i == SZ_HALF && ea[0]) || (op_size_i == SZ_WORD && ea[1:0] != 2'b00);
    idx  = ea[5:2];
    ctag = ea[31:6];
    w    = ea[9:2];
    e.tag  = op_tag_i;
    e.excp = mis;
    e.we   = (op_code_i == MEM_LOAD) && !mis;
    e.data = '0;
    if (!mis) begin
      case (op_code_i)
        MEM_LOAD: begin
          // Miss costs exactly one read and fills the line
          if (!(model_valid[idx] && model_tag[idx] == ctag)) begin
            exp_reads++;
            exp_reqs++;
            model_valid[idx] = 1'b1;
            model_tag[idx]   = ctag;
          end
          e.data = extract(model_mem[w], ea[1:0], op_size_i, op_signed_i);
        end
        MEM_STORE: begin
          exp_reqs++;
          nbytes = (op_size_i == SZ_BYTE) ? 1 : (op_size_i == SZ_HALF) ? 2 : 4;
          for (int b = 0; b < nbytes; b++) begin
            model_mem[w][8*(ea[1:0]+b) +: 8] = op_wdata_i[8*b +: 8];
          end
        end
        default: model_valid[idx] = 1'b0;
      endcase
    end
    e.reads = exp_reads;
    e.reqs  = exp_reqs;
    exp_q.push_back(e);
  endtask

  // Handshakes sampled at the rising edge, ahead of the register updates
  task automatic observe();
    wb_exp_t e;
    if (held_wb) begin
      expect_equal("wb_valid_o held", wb_valid_o, 1);
      expect_equal("writeback record held", {wb_tag_o, wb_we_o, wb_excp_o, wb_data_o}, held_rec);
    end
    if (wb_valid_o && wb_ready_i) begin
      if (exp_q.size() == 0) begin
        report_error("writeback arrived with no operation outstanding");
      end else begin
        e = exp_q.pop_front();
        expect_equal("wb_tag_o", wb_tag_o, e.tag);
        expect_equal("wb_we_o", wb_we_o, e.we);
        expect_equal("wb_excp_o", wb_excp_o, e.excp);
        expect_equal("wb_data_o", wb_data_o, e.data);
        expect_equal("memory read count", read_cnt, e.reads);
        expect_equal("memory request count", req_cnt, e.reqs);
      end
    end
    held_wb  = wb_valid_o && !wb_ready_i;
    held_rec = {wb_tag_o, wb_we_o, wb_excp_o, wb_data_o};
    if (op_valid_i && op_ready_o) begin
      model_accept();
      accepted++;
    end
    op_held = op_valid_i && !op_ready_o;
  endtask

  // ========================================================================
  // Stimulus
  // ========================================================================

  task automatic drive(input int mode, input int n);
    logic [31:0] r;
    logic [31:0] r2;
    logic [31:0] ea;
    logic [1:0]  off;
    r = $random(seed);
    wb_ready_i = (mode == 4) ? r[0] : (r[2:1] != 2'b00);
    // Request stays put until taken
    if (op_held) return;
    r = $random(seed);
    if (generated >= n || r[2:0] < 2) begin
      op_valid_i = 1'b0;
      return;
    end
    // Half the ops reuse the last word, so hits and conflicts both occur
    if (r[3]) last_word = r[9:4];
    case (mode)
      0: op_code_i = MEM_LOAD;
      1: op_code_i = r[10] ? MEM_STORE : MEM_LOAD;
      2: op_code_i = (r[11:10] == 2'b00) ? MEM_CACOP : MEM_LOAD;
      default: op_code_i = r[11] ? (r[10] ? MEM_CACOP : MEM_STORE) : MEM_LOAD;
    endcase
    case (r[13:12])
      2'd0: op_size_i = SZ_BYTE;
      2'd1: op_size_i = SZ_HALF;
      default: op_size_i = SZ_WORD;
    endcase
    if (op_code_i == MEM_CACOP) op_size_i = SZ_WORD;
    // Aligned offset unless a fault is wanted
    case (op_size_i)
      SZ_BYTE: off = r[15:14];
      SZ_HALF: off = {r[15], 1'b0};
      default: off = 2'b00;
    endcase
    if (mode == 3 || (mode == 4 && r[18:16] == 3'd0)) off = r[15:14];
    ea = 32'h1000 + {last_word, off};
    r2 = $random(seed);
    op_imm_i    = r2[11:0];
    op_base_i   = ea - {{20{r2[11]}}, r2[11:0]};
    op_wdata_i  = $random(seed);
    op_signed_i = r[19];
    op_tag_i    = next_tag;
    op_valid_i  = 1'b1;
    next_tag++;
    generated++;
  endtask

  task automatic run_test(input string name, input int mode, input int n);
    int guard;
    test_errors = 0;
    accepted    = 0;
    generated   = 0;
    guard       = 0;
    while ((accepted < n || exp_q.size() != 0) && guard < n * 50 + 500) begin
      @(negedge clk);
      drive(mode, n);
      @(posedge clk);
      observe();
      guard++;
    end
    if (accepted < n || exp_q.size() != 0) begin
      report_error($sformatf("test %s timed out with %0d writebacks still missing",
                             name, n - accepted + exp_q.size()));
      timed_out = 1'b1;
    end
    total_ops += accepted;
    $display("Test %s finished: %0d ops, %0d errors", name, accepted, test_errors);
  endtask

  initial begin
    seed        = 32'h5e4236d9;
    rst_n       = 1'b0;
    op_valid_i  = 1'b0;
    op_code_i   = MEM_LOAD;
    op_size_i   = SZ_WORD;
    op_signed_i = 1'b0;
    op_base_i   = '0;
    op_imm_i    = '0;
    op_wdata_i  = '0;
    op_tag_i    = '0;
    wb_ready_i  = 1'b0;
    errors      = 0;
    checks      = 0;
    total_ops   = 0;
    exp_reads   = 0;
    exp_reqs    = 0;
    model_valid = '0;
    timed_out   = 1'b0;
    op_held     = 1'b0;
    held_wb     = 1'b0;
    last_word   = '0;
    next_tag    = '0;
    repeat (10) @(negedge clk);
    rst_n = 1'b1;
    // Start from the responder's preloaded contents
    for (int i = 0; i < 256; i++) begin
      model_mem[i] = responder_inst.mem[i];
    end
    for (int t = 0; t < 5 && !timed_out; t++) begin
      run_test(test_name[t], t, 150);
    end
    for (int i = 0; i < 256; i++) begin
      expect_equal($sformatf("responder memory word %0d", i), responder_inst.mem[i],
                   model_mem[i]);
    end
    expect_equal("total read requests", read_cnt, exp_reads);
    $display("Summary: %0d ops, %0d checks, %0d errors", total_ops, checks, errors);
    if (errors == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

/* bench/mem_responder.sv */
module mem_responder (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        mem_req_valid_i,
  output logic        mem_req_ready_o,
  input  logic        mem_req_we_i,
  input  logic [31:0] mem_req_addr_i,
  input  logic [31:0] mem_req_wdata_i,
  input  logic [3:0]  mem_req_be_i,
  output logic        mem_rsp_valid_o,
  output logic [31:0] mem_rsp_rdata_o,
  output int          read_cnt_o,
  output int          req_cnt_o
);

  // 256 words, word address modulo 256
  logic [31:0] mem [256];
  integer      seed;
  logic        ready_new;
  logic        armed;
  int          delay;
  logic [7:0]  rd_idx;

  initial begin
    seed = 32'h5e4236d9;
    for (int i = 0; i < 256; i++) begin
      mem[i] = $random(seed);
    end
    mem_req_ready_o = 1'b0;
    mem_rsp_valid_o = 1'b0;
    mem_rsp_rdata_o = '0;
    read_cnt_o      = 0;
    req_cnt_o       = 0;
    armed           = 1'b0;
    delay           = 0;
    rd_idx          = '0;
  end

  // Handshake decided here, takes effect at the next rising edge
  always @(negedge clk) begin
    mem_rsp_valid_o <= 1'b0;
    // Stall pattern drawn every cycle
    ready_new = ($random(seed) & 3) != 0;
    if (!rst_n) begin
      mem_req_ready_o <= 1'b0;
      armed = 1'b0;
    end else begin
      mem_req_ready_o <= ready_new;
      // Read answered 1 to 4 cycles after acceptance
      if (armed) begin
        if (delay == 0) begin
          mem_rsp_valid_o <= 1'b1;
          mem_rsp_rdata_o <= mem[rd_idx];
          armed = 1'b0;
        end else begin
          delay = delay - 1;
        end
      end
      if (mem_req_valid_i && ready_new) begin
        req_cnt_o <= req_cnt_o + 1;
        if (mem_req_we_i) begin
          for (int b = 0; b < 4; b++) begin
            if (mem_req_be_i[b]) mem[mem_req_addr_i[9:2]][8*b +: 8] = mem_req_wdata_i[8*b +: 8];
          end
        end else begin
          read_cnt_o <= read_cnt_o + 1;
          armed  = 1'b1;
          delay  = $random(seed) & 3;
          rd_idx = mem_req_addr_i[9:2];
        end
      end
    end
  end

endmodule

/* logic/mem_unit.sv */
module mem_unit import lsu_pkg::*; (
  input  logic             clk,
  input  logic             rst_n,
  // Operation in
  input  logic             op_valid_i,
  output logic             op_ready_o,
  input  mem_op_e          op_code_i,
  input  mem_size_e        op_size_i,
  input  logic             op_signed_i,
  input  logic [XLEN-1:0]  op_base_i,
  input  logic [IMM_W-1:0] op_imm_i,
  input  logic [XLEN-1:0]  op_wdata_i,
  input  logic [TAG_W-1:0] op_tag_i,
  // Memory port
  output logic             mem_req_valid_o,
  input  logic             mem_req_ready_i,
  output logic             mem_req_we_o,
  output logic [XLEN-1:0]  mem_req_addr_o,
  output logic [XLEN-1:0]  mem_req_wdata_o,
  output logic [BE_W-1:0]  mem_req_be_o,
  input  logic             mem_rsp_valid_i,
  input  logic [XLEN-1:0]  mem_rsp_rdata_i,
  // Writeback
  output logic             wb_valid_o,
  input  logic             wb_ready_i,
  output logic             wb_we_o,
  output logic [XLEN-1:0]  wb_data_o,
  output logic [TAG_W-1:0] wb_tag_o,
  output logic             wb_excp_o
);

  // Stage links
  lsu_req_if req_bus ();
  lsu_rsp_if rsp_bus ();

  // ========================================================================
  // Decode, execute, result
  // ========================================================================

  mem_decode u_decode (
    .clk         (clk),
    .rst_n       (rst_n),
    .op_valid_i  (op_valid_i),
    .op_code_i   (op_code_i),
    .op_size_i   (op_size_i),
    .op_signed_i (op_signed_i),
    .op_base_i   (op_base_i),
    .op_imm_i    (op_imm_i),
    .op_wdata_i  (op_wdata_i),
    .op_tag_i    (op_tag_i),
    .op_ready_o  (op_ready_o),
    .req         (req_bus.src)
  );

  dcache_exec u_dcache (
    .clk             (clk),
    .rst_n           (rst_n),
    .req             (req_bus.snk),
    .rsp             (rsp_bus.src),
    .mem_req_valid_o (mem_req_valid_o),
    .mem_req_ready_i (mem_req_ready_i),
    .mem_req_we_o    (mem_req_we_o),
    .mem_req_addr_o  (mem_req_addr_o),
    .mem_req_wdata_o (mem_req_wdata_o),
    .mem_req_be_o    (mem_req_be_o),
    .mem_rsp_valid_i (mem_rsp_valid_i),
    .mem_rsp_rdata_i (mem_rsp_rdata_i)
  );

  mem_result u_result (
    .rsp        (rsp_bus.snk),
    .wb_ready_i (wb_ready_i),
    .wb_valid_o (wb_valid_o),
    .wb_we_o    (wb_we_o),
    .wb_data_o  (wb_data_o),
    .wb_tag_o   (wb_tag_o),
    .wb_excp_o  (wb_excp_o)
  );

endmodule

/* logic/mem_result.sv */
module mem_result import lsu_pkg::*; (
  lsu_rsp_if.snk           rsp,
  input  logic             wb_ready_i,
  output logic             wb_valid_o,
  output logic             wb_we_o,
  output logic [XLEN-1:0]  wb_data_o,
  output logic [TAG_W-1:0] wb_tag_o,
  output logic             wb_excp_o
);

  logic            load_ok;
  logic [7:0]      byte_sel;
  logic [15:0]     half_sel;
  logic [XLEN-1:0] ext_data;

  // ========================================================================
  // Handshake, straight through
  // ========================================================================

  assign rsp.ready  = wb_ready_i;
  assign wb_valid_o = rsp.valid;

  // Only a clean load writes a register
  assign load_ok = (rsp.op == MEM_LOAD) & ~rsp.excp;

  // ========================================================================
  // Lane select and extension
  // ========================================================================

  // Addressed byte
  assign byte_sel = rsp.rdata[{rsp.boff, 3'b000} +: 8];
  // Half is aligned, so only offset bit 1 matters
  assign half_sel = rsp.rdata[{rsp.boff[1], 4'b0000} +: 16];

  always_comb begin
    case (rsp.size)
      SZ_BYTE: begin
        if (rsp.sgn) begin
          ext_data = {{(XLEN-8){byte_sel[7]}}, byte_sel};
        end else begin
          ext_data = {{(XLEN-8){1'b0}}, byte_sel};
        end
      end
      SZ_HALF: begin
        if (rsp.sgn) begin
          ext_data = {{(XLEN-16){half_sel[15]}}, half_sel};
        end else begin
          ext_data = {{(XLEN-16){1'b0}}, half_sel};
        end
      end
      // Full word, nothing to extend
      default: ext_data = rsp.rdata;
    endcase
  end

  // ========================================================================
  // Writeback record
  // ========================================================================

  assign wb_we_o   = load_ok;
  // Stores, cacops and faults carry zero
  assign wb_data_o = load_ok ? ext_data : '0;
  assign wb_tag_o  = rsp.tag;
  assign wb_excp_o = rsp.excp;

endmodule

/* logic/dcache_exec.sv */
module dcache_exec import lsu_pkg::*; (
  input  logic             clk,
  input  logic             rst_n,
  lsu_req_if.snk           req,
  lsu_rsp_if.src           rsp,
  output logic             mem_req_valid_o,
  input  logic             mem_req_ready_i,
  output logic             mem_req_we_o,
  output logic [XLEN-1:0]  mem_req_addr_o,
  output logic [XLEN-1:0]  mem_req_wdata_o,
  output logic [BE_W-1:0]  mem_req_be_o,
  input  logic             mem_rsp_valid_i,
  input  logic [XLEN-1:0]  mem_rsp_rdata_i
);

  // Line storage
  logic [LINE_CNT-1:0] valid_q;
  logic [CTAG_W-1:0]   tag_q  [LINE_CNT];
  logic [XLEN-1:0]     data_q [LINE_CNT];

  dc_state_e         state_q;
  dc_state_e         state_d;
  dc_state_e         entry_state;
  mem_req_t          cur_q;
  logic [XLEN-1:0]   rdata_q;

  logic              accept;
  logic [IDX_W-1:0]  in_idx;
  logic [CTAG_W-1:0] in_ctag;
  logic              in_hit;
  logic [IDX_W-1:0]  cur_idx;
  logic [CTAG_W-1:0] cur_ctag;

  // ========================================================================
  // Lookup of the incoming request
  // ========================================================================

  assign in_idx  = req.pkt.waddr[IDX_W-1:0];
  assign in_ctag = req.pkt.waddr[WADDR_W-1:IDX_W];
  assign in_hit  = valid_q[in_idx] & (tag_q[in_idx] == in_ctag);

  // Request currently owned by the FSM
  assign cur_idx  = cur_q.waddr[IDX_W-1:0];
  assign cur_ctag = cur_q.waddr[WADDR_W-1:IDX_W];

  // New request only when idle or the response leaves now
  assign req.ready = (state_q == DC_IDLE) | ((state_q == DC_RESP) & rsp.ready);
  assign accept    = req.valid & req.ready;

  // Where a freshly accepted op goes
  always_comb begin
    entry_state = DC_RESP;
    if (!req.pkt.misaligned) begin
      case (req.pkt.op)
        MEM_LOAD:  entry_state = in_hit ? DC_RESP : DC_REFILL_REQ;
        MEM_STORE: entry_state = DC_STORE_REQ;
        // Cacop is done at acceptance
        default:   entry_state = DC_RESP;
      endcase
    end
  end

  // ========================================================================
  // Controller FSM
  // ========================================================================

  always_comb begin
    state_d = state_q;
    case (state_q)
      DC_IDLE: begin
        if (req.valid) state_d = entry_state;
      end
      DC_REFILL_REQ: begin
        if (mem_req_ready_i) state_d = DC_REFILL_WAIT;
      end
      DC_REFILL_WAIT: begin
        if (mem_rsp_valid_i) state_d = DC_RESP;
      end
      DC_STORE_REQ: begin
        // Write is done once accepted
        if (mem_req_ready_i) state_d = DC_RESP;
      end
      DC_RESP: begin
        if (rsp.ready) state_d = req.valid ? entry_state : DC_IDLE;
      end
      default: state_d = DC_IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= DC_IDLE;
      valid_q <= '0;
    end else begin
      state_q <= state_d;
      // Cacop drops its line
      if (accept && req.pkt.op == MEM_CACOP && !req.pkt.misaligned) begin
        valid_q[in_idx] <= 1'b0;
      end
      if (state_q == DC_REFILL_WAIT && mem_rsp_valid_i) begin
        valid_q[cur_idx] <= 1'b1;
      end
    end
  end

  // ========================================================================
  // Payload, tags and data
  // ========================================================================

  always_ff @(posedge clk) begin
    if (accept) begin
      cur_q <= req.pkt;
      // Hit data captured with the request
      if (req.pkt.op == MEM_LOAD) begin
        rdata_q <= data_q[in_idx];
      end
      // Store hit merges its lanes, a miss allocates nothing
      if (req.pkt.op == MEM_STORE && !req.pkt.misaligned && in_hit) begin
        for (int b = 0; b < BE_W; b++) begin
          if (req.pkt.be[b]) begin
            data_q[in_idx][8*b +: 8] <= req.pkt.wdata[8*b +: 8];
          end
        end
      end
    end
    // Refill of the whole line
    if (state_q == DC_REFILL_WAIT && mem_rsp_valid_i) begin
      tag_q[cur_idx]  <= cur_ctag;
      data_q[cur_idx] <= mem_rsp_rdata_i;
      rdata_q         <= mem_rsp_rdata_i;
    end
  end

  // ========================================================================
  // Memory port
  // ========================================================================

  assign mem_req_valid_o = (state_q == DC_REFILL_REQ) | (state_q == DC_STORE_REQ);
  assign mem_req_we_o    = state_q == DC_STORE_REQ;
  assign mem_req_addr_o  = {cur_q.waddr, 2'b00};
  assign mem_req_wdata_o = cur_q.wdata;
  // Reads fetch the full word
  assign mem_req_be_o    = (state_q == DC_STORE_REQ) ? cur_q.be : '1;

  // Response toward result stage
  assign rsp.valid = state_q == DC_RESP;
  assign rsp.rdata = rdata_q;
  assign rsp.boff  = cur_q.boff;
  assign rsp.size  = cur_q.size;
  assign rsp.sgn   = cur_q.sgn;
  assign rsp.op    = cur_q.op;
  assign rsp.tag   = cur_q.tag;
  assign rsp.excp  = cur_q.misaligned;

endmodule

/* logic/mem_decode.sv */
module mem_decode import lsu_pkg::*; (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             op_valid_i,
  input  mem_op_e          op_code_i,
  input  mem_size_e        op_size_i,
  input  logic             op_signed_i,
  input  logic [XLEN-1:0]  op_base_i,
  input  logic [IMM_W-1:0] op_imm_i,
  input  logic [XLEN-1:0]  op_wdata_i,
  input  logic [TAG_W-1:0] op_tag_i,
  output logic             op_ready_o,
  lsu_req_if.src           req
);

  logic            live_q;
  logic            valid_q;
  logic            accept;
  logic [XLEN-1:0] ea;
  logic            misaligned;
  logic [BE_W-1:0] be_base;
  logic [XLEN-1:0] wdata_masked;
  mem_req_t        pkt_d;
  mem_req_t        pkt_q;

  // ========================================================================
  // Handshake
  // ========================================================================

  // Free when empty or when exec drains the entry this cycle
  assign op_ready_o = live_q & (~valid_q | req.ready);
  assign accept     = op_valid_i & op_ready_o;

  // ========================================================================
  // Address and lane generation
  // ========================================================================

  // Base plus sign-extended immediate
  assign ea = op_base_i + {{(XLEN-IMM_W){op_imm_i[IMM_W-1]}}, op_imm_i};

  always_comb begin
    misaligned   = 1'b0;
    be_base      = '1;
    wdata_masked = op_wdata_i;
    case (op_size_i)
      SZ_BYTE: begin
        be_base      = 4'b0001;
        wdata_masked = {24'd0, op_wdata_i[7:0]};
      end
      SZ_HALF: begin
        // Odd address
        misaligned   = ea[0];
        be_base      = 4'b0011;
        wdata_masked = {16'd0, op_wdata_i[15:0]};
      end
      default: begin
        // Not on a 4-byte boundary
        misaligned   = |ea[1:0];
      end
    endcase
  end

  // Fields of the decoded op
  always_comb begin
    pkt_d.op         = op_code_i;
    pkt_d.size       = op_size_i;
    pkt_d.sgn        = op_signed_i;
    pkt_d.waddr      = ea[XLEN-1:2];
    pkt_d.boff       = ea[1:0];
    // No lanes enabled for a faulting access
    pkt_d.be         = misaligned ? '0 : be_base << ea[1:0];
    pkt_d.wdata      = wdata_masked << {ea[1:0], 3'b000};
    pkt_d.tag        = op_tag_i;
    pkt_d.misaligned = misaligned;
  end

  // ========================================================================
  // Stage register
  // ========================================================================

  // Ready held off for the first cycle out of reset
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      live_q  <= 1'b0;
      valid_q <= 1'b0;
    end else begin
      live_q <= 1'b1;
      if (accept) begin
        valid_q <= 1'b1;
      end else if (req.ready) begin
        valid_q <= 1'b0;
      end
    end
  end

  // Payload only
  always_ff @(posedge clk) begin
    if (accept) begin
      pkt_q <= pkt_d;
    end
  end

  assign req.valid = valid_q;
  assign req.pkt   = pkt_q;

endmodule

/* logic/lsu_if.sv */
// Decoded request, decode stage to cache
interface lsu_req_if import lsu_pkg::*; ();

  logic     valid;
  logic     ready;
  // Held stable while valid and not ready
  mem_req_t pkt;

  modport src (
    output valid,
    output pkt,
    input  ready
  );

  modport snk (
    input  valid,
    input  pkt,
    output ready
  );

endinterface

// Cache response, cache to result formatting
interface lsu_rsp_if import lsu_pkg::*; ();

  logic             valid;
  logic             ready;
  // Raw word, lane select happens downstream
  logic [XLEN-1:0]  rdata;
  logic [1:0]       boff;
  mem_size_e        size;
  logic             sgn;
  mem_op_e          op;
  logic [TAG_W-1:0] tag;
  logic             excp;

  modport src (
    output valid, rdata, boff, size, sgn, op, tag, excp,
    input  ready
  );

  modport snk (
    input  valid, rdata, boff, size, sgn, op, tag, excp,
    output ready
  );

endinterface

/* logic/lsu_pkg.sv */
package lsu_pkg;

  // ========================================================================
  // Widths and sizes
  // ========================================================================

  // Data and address width
  localparam int XLEN = 32;
  // Operation tag carried through to writeback
  localparam int TAG_W = 4;
  // Immediate, sign-extended before the add
  localparam int IMM_W = 12;
  // One byte enable per byte lane
  localparam int BE_W = XLEN / 8;
  // Word address, byte offset dropped
  localparam int WADDR_W = XLEN - 2;

  // Direct-mapped, one word per line
  localparam int LINE_CNT = 16;
  // Index comes from address bits 5..2
  localparam int IDX_W = 4;
  // Remaining upper address bits
  localparam int CTAG_W = XLEN - IDX_W - 2;

  // ========================================================================
  // Enums
  // ========================================================================

  typedef enum logic [1:0] {
    MEM_LOAD,
    MEM_STORE,
    MEM_CACOP
  } mem_op_e;

  typedef enum logic [1:0] {
    SZ_BYTE,
    SZ_HALF,
    SZ_WORD
  } mem_size_e;

  // Cache controller
  typedef enum logic [2:0] {
    DC_IDLE,
    DC_REFILL_REQ,
    DC_REFILL_WAIT,
    DC_STORE_REQ,
    DC_RESP
  } dc_state_e;

  // ========================================================================
  // Decoded operation, decode to exec
  // ========================================================================

  typedef struct packed {
    mem_op_e              op;
    mem_size_e            size;
    logic                 sgn;
    logic [WADDR_W-1:0]   waddr;
    logic [1:0]           boff;
    logic [BE_W-1:0]      be;
    // Already moved to its byte lanes
    logic [XLEN-1:0]      wdata;
    logic [TAG_W-1:0]     tag;
    logic                 misaligned;
  } mem_req_t;

endpackage
